// ==== Bender.yml ====
package:
  name: fetch

sources:
  - fetch_pkg.sv
  - fe_fb_if.sv
  - fe_pc_ctl.sv
  - fe_buf.sv
  - fe_out.sv
  - fetch.sv
  - target: test
    files:
      - tb_clkgen.sv
      - fetch_chk.sv
      - fetch_tb.sv

// ==== fe_buf.sv ====
`default_nettype none

module fe_buf (
    input  wire logic                         clk,
    input  wire logic                         reset,

    fe_fb_if.buf_mp                           fb,

    // instruction cache request
    output logic                              ic_req_valid,
    output logic [fetch_pkg::ADDR_W-1:0]      ic_req_addr,

    // instruction cache response
    input  wire logic                         ic_rsp_valid,
    input  wire logic [fetch_pkg::LINE_W-1:0] ic_rsp_data
);

    // ########################################
    // held line
    // ########################################

    logic [fetch_pkg::LINE_WORDS-1:0][31:0]           line_q;       // line data
    logic [fetch_pkg::ADDR_W-1:fetch_pkg::LINE_LSB]   tag_q;        // line address of line_q
    logic                                             line_valid_q; // line_q is usable

    // ########################################
    // miss tracking
    // ########################################

    logic                                             waiting_q;    // request outstanding
    logic [fetch_pkg::ADDR_W-1:fetch_pkg::LINE_LSB]   req_tag_q;    // line being fetched

    logic [fetch_pkg::ADDR_W-1:fetch_pkg::LINE_LSB]   pc_tag;       // line address of pc
    logic [fetch_pkg::OFS_W-1:0]                      pc_ofs;       // word in line
    logic                                             hit;
    logic                                             send_req;     // miss goes out next edge

    assign pc_tag = fb.pc[fetch_pkg::ADDR_W-1:fetch_pkg::LINE_LSB];
    assign pc_ofs = fb.pc[fetch_pkg::LINE_LSB-1 -: fetch_pkg::OFS_W];

    assign hit      = line_valid_q && (tag_q == pc_tag);
    assign send_req = !hit && !waiting_q; // one miss in flight at most

    // lookup is combinational in the pc cycle
    assign fb.hit   = hit;
    assign fb.instr = line_q[pc_ofs];

    // request side, pulse one cycle after the miss
    always_ff @(posedge clk) begin
        if (reset) begin
            ic_req_valid <= 1'b0;
            waiting_q    <= 1'b0;
        end else begin
            ic_req_valid <= send_req;
            if (send_req) begin
                waiting_q <= 1'b1;         // held until the response
            end else if (ic_rsp_valid) begin
                waiting_q <= 1'b0;         // free for the next miss
            end
        end
    end

    always_ff @(posedge clk) begin
        if (send_req) begin
            req_tag_q <= pc_tag;           // pc may be redirected meanwhile
        end
    end

    assign ic_req_addr = {req_tag_q, {fetch_pkg::LINE_LSB{1'b0}}}; // line aligned

    // ########################################
    // line fill
    // ########################################

    // a fill that lands after a redirect is kept, the tag still names it
    always_ff @(posedge clk) begin
        if (reset) begin
            line_valid_q <= 1'b0;
        end else if (ic_rsp_valid && waiting_q) begin
            line_valid_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (ic_rsp_valid && waiting_q) begin
            line_q <= ic_rsp_data;         // word i at request addr + 4*i
            tag_q  <= req_tag_q;
        end
    end

endmodule

`default_nettype wire

// ==== fe_fb_if.sv ====
`default_nettype none

interface fe_fb_if;

    // from the pc controller
    logic [fetch_pkg::ADDR_W-1:0] pc;    // current fetch address
    logic                         flush; // redirect this cycle, nuke or mispredict

    // from the fetch buffer
    logic                         hit;   // pc line is held in the buffer
    logic [31:0]                  instr; // word of the held line at pc

    // from the output stage
    logic                         advance; // fe1 takes the word at pc

    modport pc_mp (
        output pc,
        output flush,
        input  advance
    );

    modport buf_mp (
        input  pc,
        output hit,
        output instr
    );

    modport out_mp (
        input  pc,
        input  hit,
        input  instr,
        input  flush,
        output advance
    );

endinterface

`default_nettype wire

// ==== fe_out.sv ====
`default_nettype none

module fe_out (
    input  wire logic                    clk,
    input  wire logic                    reset,

    fe_fb_if.out_mp                      fb,

    input  wire logic                    decode_ready_de0,

    output logic                         valid_fe1,
    output logic [fetch_pkg::ADDR_W-1:0] pc_fe1,
    output logic [31:0]                  instr_fe1
);

    logic stage_free; // fe1 empty or taken by decode this cycle
    logic advance;

    // ########################################
    // advance
    // ########################################

    assign stage_free = !valid_fe1 || decode_ready_de0;

    // a redirect cycle never advances, the pc is stale
    assign advance = fb.hit && !fb.flush && stage_free;

    assign fb.advance = advance;

    // ########################################
    // fe1 stage
    // ########################################

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_fe1 <= 1'b0;
        end else if (advance) begin
            valid_fe1 <= 1'b1;         // new word in fe1
        end else if (fb.flush) begin
            valid_fe1 <= 1'b0;         // drop the wrong path word
        end else if (decode_ready_de0) begin
            valid_fe1 <= 1'b0;         // taken, nothing behind it
        end
    end

    // payload only moves on advance so a stall holds it as is
    always_ff @(posedge clk) begin
        if (advance) begin
            pc_fe1    <= fb.pc;
            instr_fe1 <= fb.instr;
        end
    end

endmodule

`default_nettype wire

// ==== fe_pc_ctl.sv ====
`default_nettype none

module fe_pc_ctl (
    input  wire logic                         clk,
    input  wire logic                         reset,

    fe_fb_if.pc_mp                            fb,

    input  wire logic                         br_mispred_valid_ex0,
    input  wire logic [fetch_pkg::ADDR_W-1:0] br_mispred_target_ex0,

    input  wire logic                         nuke_valid_rb1,
    input  wire logic [fetch_pkg::ADDR_W-1:0] nuke_pc_rb1
);

    logic [fetch_pkg::ADDR_W-1:0] pc_q;        // fetch pc register
    logic [fetch_pkg::ADDR_W-1:0] pc_nxt;      // next fetch pc
    logic [fetch_pkg::ADDR_W-1:0] redirect_pc; // winning redirect target
    logic                         redirect;    // any redirect this cycle

    // ########################################
    // redirect select
    // ########################################

    assign redirect = nuke_valid_rb1 | br_mispred_valid_ex0;

    always_comb begin
        redirect_pc = br_mispred_target_ex0; // mispredict by default
        if (nuke_valid_rb1) begin
            redirect_pc = nuke_pc_rb1;       // nuke is older, wins
        end
    end

    // ########################################
    // next pc
    // ########################################

    always_comb begin
        pc_nxt = pc_q;                       // hold while nothing moves
        if (redirect) begin
            pc_nxt = redirect_pc;            // new path from the next edge
        end else if (fb.advance) begin
            pc_nxt = pc_q + 'd4;             // sequential step
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc_q <= fetch_pkg::RESET_PC;
        end else begin
            pc_q <= pc_nxt;
        end
    end

    // the only place the redirect inputs are looked at, the buffer and the
    // output stage follow flush instead
    assign fb.pc    = pc_q;
    assign fb.flush = redirect;

endmodule

`default_nettype wire

// ==== fetch.f ====
fetch_pkg.sv
fe_fb_if.sv
fe_pc_ctl.sv
fe_buf.sv
fe_out.sv
fetch.sv
tb_clkgen.sv
fetch_chk.sv
fetch_tb.sv

// ==== fetch.sv ====
`default_nettype none

module fetch (
    input  wire logic                         clk,
    input  wire logic                         reset,

    // instruction cache
    output logic                              ic_req_valid,
    output logic [fetch_pkg::ADDR_W-1:0]      ic_req_addr,
    input  wire logic                         ic_rsp_valid,
    input  wire logic [fetch_pkg::LINE_W-1:0] ic_rsp_data,

    // redirects
    input  wire logic                         br_mispred_valid_ex0,
    input  wire logic [fetch_pkg::ADDR_W-1:0] br_mispred_target_ex0,
    input  wire logic                         nuke_valid_rb1,
    input  wire logic [fetch_pkg::ADDR_W-1:0] nuke_pc_rb1,

    // decode
    input  wire logic                         decode_ready_de0,
    output logic                              valid_fe1,
    output logic [fetch_pkg::ADDR_W-1:0]      pc_fe1,
    output logic [31:0]                       instr_fe1
);

    // ########################################
    // pc, buffer and fe1 glue
    // ########################################

    fe_fb_if fb ();

    fe_pc_ctl pc_ctl0 (
        .clk                   (clk),
        .reset                 (reset),
        .fb                    (fb),
        .br_mispred_valid_ex0  (br_mispred_valid_ex0),
        .br_mispred_target_ex0 (br_mispred_target_ex0),
        .nuke_valid_rb1        (nuke_valid_rb1),
        .nuke_pc_rb1           (nuke_pc_rb1)
    );

    fe_buf buf0 (
        .clk          (clk),
        .reset        (reset),
        .fb           (fb),
        .ic_req_valid (ic_req_valid),
        .ic_req_addr  (ic_req_addr),
        .ic_rsp_valid (ic_rsp_valid),
        .ic_rsp_data  (ic_rsp_data)
    );

    fe_out out0 (
        .clk              (clk),
        .reset            (reset),
        .fb               (fb),
        .decode_ready_de0 (decode_ready_de0),
        .valid_fe1        (valid_fe1),
        .pc_fe1           (pc_fe1),
        .instr_fe1        (instr_fe1)
    );

endmodule

`default_nettype wire

// ==== fetch_chk.sv ====
`default_nettype none

module fetch_chk (
    input wire logic                         clk,
    input wire logic                         reset,
    input wire logic                         ic_req_valid,
    input wire logic [fetch_pkg::ADDR_W-1:0] ic_req_addr,
    input wire logic                         ic_rsp_valid,
    input wire logic                         br_mispred_valid_ex0,
    input wire logic                         nuke_valid_rb1,
    input wire logic                         decode_ready_de0,
    input wire logic                         valid_fe1,
    input wire logic [fetch_pkg::ADDR_W-1:0] pc_fe1,
    input wire logic [31:0]                  instr_fe1
);

    int unsigned fail_cnt = 0;           // read by the testbench monitor

    logic outstanding_q;                 // request sent, no response yet
    logic after_reset_q;                 // previous edge saw reset
    logic redirect;

    assign redirect = nuke_valid_rb1 || br_mispred_valid_ex0;

    always_ff @(posedge clk) begin
        if (reset) begin
            outstanding_q <= 1'b0;
        end else if (ic_req_valid) begin
            outstanding_q <= 1'b1;
        end else if (ic_rsp_valid) begin
            outstanding_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        after_reset_q <= reset;
    end

    // ########################################
    // icache side
    // ########################################

    a_one_outstanding: assert property (@(posedge clk) disable iff (reset)
        ic_req_valid |-> !outstanding_q)
    else begin
        $error("ic_req_valid while a request is outstanding");
        fail_cnt++;
    end

    a_req_aligned: assert property (@(posedge clk) disable iff (reset)
        ic_req_valid |-> (ic_req_addr[fetch_pkg::LINE_LSB-1:0] == '0))
    else begin
        $error("ic_req_addr not line aligned");
        fail_cnt++;
    end

    // ########################################
    // decode side
    // ########################################

    a_stall_hold: assert property (@(posedge clk) disable iff (reset)
        (valid_fe1 && !decode_ready_de0 && !redirect)
            |=> (valid_fe1 && $stable(pc_fe1) && $stable(instr_fe1)))
    else begin
        $error("fe1 outputs changed under stall");
        fail_cnt++;
    end

    a_flush_clears: assert property (@(posedge clk) disable iff (reset)
        redirect |=> !valid_fe1)
    else begin
        $error("valid_fe1 high in the cycle after a redirect");
        fail_cnt++;
    end

    // covers the reset cycles and the first cycle after release
    a_quiet_after_reset: assert property (@(posedge clk)
        after_reset_q |-> (!valid_fe1 && !ic_req_valid))
    else begin
        $error("valid_fe1 or ic_req_valid high around reset");
        fail_cnt++;
    end

endmodule

bind fetch fetch_chk chk0 (
    .clk                  (clk),
    .reset                (reset),
    .ic_req_valid         (ic_req_valid),
    .ic_req_addr          (ic_req_addr),
    .ic_rsp_valid         (ic_rsp_valid),
    .br_mispred_valid_ex0 (br_mispred_valid_ex0),
    .nuke_valid_rb1       (nuke_valid_rb1),
    .decode_ready_de0     (decode_ready_de0),
    .valid_fe1            (valid_fe1),
    .pc_fe1               (pc_fe1),
    .instr_fe1            (instr_fe1)
);

`default_nettype wire

// ==== fetch_pkg.sv ====
`default_nettype none

package fetch_pkg;

    // ########################################
    // fetch address
    // ########################################

    localparam int unsigned ADDR_W = 32;                 // byte address width

    // fetch restarts here out of reset
    localparam logic [ADDR_W-1:0] RESET_PC = 32'h0000_1000;

    // ########################################
    // instruction cache line geometry
    // ########################################

    localparam int unsigned LINE_WORDS = 4;              // 32 bit words per line
    localparam int unsigned LINE_W     = LINE_WORDS * 32; // whole line, 128 bits

    // word pick inside a line, pc[3:2]
    localparam int unsigned OFS_W = 2;

    // lowest tag bit, lines sit on 16 byte boundaries
    localparam int unsigned LINE_LSB = 4;

    // the tag is pc[ADDR_W-1:LINE_LSB] and the word index sits right below it,
    // pc[1:0] is always zero since there are no compressed instructions

endpackage

`default_nettype wire

// ==== fetch_tb.sv ====
`default_nettype none

module fetch_tb;

    logic                         clk;
    logic                         reset;
    logic                         ic_req_valid;
    logic [fetch_pkg::ADDR_W-1:0] ic_req_addr;
    logic                         ic_rsp_valid;
    logic [fetch_pkg::LINE_W-1:0] ic_rsp_data;
    logic                         br_mispred_valid_ex0;
    logic [fetch_pkg::ADDR_W-1:0] br_mispred_target_ex0;
    logic                         nuke_valid_rb1;
    logic [fetch_pkg::ADDR_W-1:0] nuke_pc_rb1;
    logic                         decode_ready_de0;
    logic                         valid_fe1;
    logic [fetch_pkg::ADDR_W-1:0] pc_fe1;
    logic [31:0]                  instr_fe1;

    integer seed = 32'hc453_9e79;

    logic [31:0]                  rnd;          // per cycle random word
    logic [31:0]                  tgt_rnd;
    logic                         rsp_pending;  // icache model busy
    logic [fetch_pkg::ADDR_W-1:0] rsp_addr;
    int unsigned                  rsp_wait;
    logic [fetch_pkg::ADDR_W-1:0] exp_pc;       // next pc decode should see
    int unsigned                  n_accept    = 0;
    int unsigned                  n_mispred   = 0;
    int unsigned                  n_nuke      = 0;
    int unsigned                  n_both      = 0;
    int unsigned                  n_miss_redir = 0;
    int unsigned                  wait_cycles;
    int unsigned                  idle_cycles;
    int unsigned                  last_accept;

    tb_clkgen clkgen0 (
        .clk   (clk),
        .reset (reset)
    );

    fetch dut0 (
        .clk                   (clk),
        .reset                 (reset),
        .ic_req_valid          (ic_req_valid),
        .ic_req_addr           (ic_req_addr),
        .ic_rsp_valid          (ic_rsp_valid),
        .ic_rsp_data           (ic_rsp_data),
        .br_mispred_valid_ex0  (br_mispred_valid_ex0),
        .br_mispred_target_ex0 (br_mispred_target_ex0),
        .nuke_valid_rb1        (nuke_valid_rb1),
        .nuke_pc_rb1           (nuke_pc_rb1),
        .decode_ready_de0      (decode_ready_de0),
        .valid_fe1             (valid_fe1),
        .pc_fe1                (pc_fe1),
        .instr_fe1             (instr_fe1)
    );

    // ########################################
    // reference and helpers
    // ########################################

    // memory content, depends on every address bit
    function automatic logic [31:0] rom_word(input logic [fetch_pkg::ADDR_W-1:0] addr);
        return (addr * 32'h9e37_79b1) ^ 32'h5a5a_c3c3;
    endfunction

    function automatic logic [fetch_pkg::LINE_W-1:0] make_line(
        input logic [fetch_pkg::ADDR_W-1:0] line_addr
    );
        logic [fetch_pkg::LINE_W-1:0] line;
        line = '0;
        for (int i = 0; i < fetch_pkg::LINE_WORDS; i++) begin
            line[32*i +: 32] = rom_word(line_addr + 32'(4 * i)); // word i at addr + 4i
        end
        return line;
    endfunction

    // word aligned redirect target, sometimes inside the line at fe1
    function automatic logic [fetch_pkg::ADDR_W-1:0] pick_target(
        input logic [31:0]                  r,
        input logic                         fe1_valid,
        input logic [fetch_pkg::ADDR_W-1:0] fe1_pc
    );
        if (r[1:0] == 2'd0 && fe1_valid) begin
            return {fe1_pc[fetch_pkg::ADDR_W-1:fetch_pkg::LINE_LSB],
                    r[fetch_pkg::LINE_LSB-1:2], 2'b00};          // held line, any word
        end else if (r[1:0] == 2'd1) begin
            return fetch_pkg::RESET_PC + (r & 32'h0000_0ff0);   // line start
        end
        return fetch_pkg::RESET_PC + (r & 32'h0000_0ffc);       // mid line
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Test FAILED");
        $fatal(1, "simulation stopped at time %0t", $time);
    endtask

    task automatic compare_value(
        input string       what,
        input logic [31:0] got,
        input logic [31:0] expected
    );
        if (got !== expected) begin
            $display("Error at time %0t: %s is %h, expected %h", $time, what, got, expected);
            abort_run("fe1 output does not match the reference");
        end
    endtask

    // ########################################
    // stimulus and icache model
    // ########################################

    initial begin
        ic_rsp_valid          = 1'b0;
        ic_rsp_data           = '0;
        br_mispred_valid_ex0  = 1'b0;
        br_mispred_target_ex0 = '0;
        nuke_valid_rb1        = 1'b0;
        nuke_pc_rb1           = '0;
        decode_ready_de0      = 1'b0;
        rsp_pending           = 1'b0;
        rsp_addr              = '0;
        rsp_wait              = 0;
    end

    always @(posedge clk) begin
        rnd     = $random(seed);
        tgt_rnd = $random(seed);
        br_mispred_valid_ex0 <= 1'b0;       // redirects are one cycle pulses
        nuke_valid_rb1       <= 1'b0;
        ic_rsp_valid         <= 1'b0;
        if (reset) begin
            decode_ready_de0 <= 1'b0;
            rsp_pending      = 1'b0;
        end else begin
            decode_ready_de0 <= (rnd[1:0] != 2'd0); // ready 3 of 4 cycles
            if (ic_req_valid) begin
                if (rsp_pending) begin
                    abort_run("icache model got a second request before answering the first");
                end
                rsp_pending = 1'b1;
                rsp_addr    = ic_req_addr;
                rsp_wait    = 1 + (rnd[31:16] % 6);  // 1 to 6 cycles
            end else if (rsp_pending) begin
                rsp_wait = rsp_wait - 1;
                if (rsp_wait == 0) begin
                    ic_rsp_valid <= 1'b1;
                    ic_rsp_data  <= make_line(rsp_addr);
                    rsp_pending  = 1'b0;
                end
            end
            // rare redirects, more often while a miss is out
            if (rnd[7:2] == 6'd0 || (rsp_pending && rnd[11:8] == 4'd0)) begin
                if (rsp_pending) begin
                    n_miss_redir++;
                end
                case (rnd[13:12])
                    2'd1: begin
                        nuke_valid_rb1 <= 1'b1;
                        nuke_pc_rb1    <= pick_target(tgt_rnd, valid_fe1, pc_fe1);
                        n_nuke++;
                    end
                    2'd2: begin                       // both, nuke must win
                        nuke_valid_rb1        <= 1'b1;
                        nuke_pc_rb1           <= pick_target(tgt_rnd, valid_fe1, pc_fe1);
                        br_mispred_valid_ex0  <= 1'b1;
                        br_mispred_target_ex0 <= pick_target(~tgt_rnd, valid_fe1, pc_fe1);
                        n_both++;
                    end
                    default: begin
                        br_mispred_valid_ex0  <= 1'b1;
                        br_mispred_target_ex0 <= pick_target(tgt_rnd, valid_fe1, pc_fe1);
                        n_mispred++;
                    end
                endcase
            end
        end
    end

    // ########################################
    // compare
    // ########################################

    always @(posedge clk) begin
        if (reset) begin
            exp_pc = fetch_pkg::RESET_PC;
        end else begin
            if (valid_fe1 && decode_ready_de0) begin   // delivered this cycle
                compare_value("pc_fe1", pc_fe1, exp_pc);
                compare_value("instr_fe1", instr_fe1, rom_word(exp_pc));
                exp_pc = exp_pc + 32'd4;
                n_accept++;
            end
            if (nuke_valid_rb1) begin
                exp_pc = nuke_pc_rb1;                  // older, wins
            end else if (br_mispred_valid_ex0) begin
                exp_pc = br_mispred_target_ex0;
            end
        end
    end

    // bound assertions count their failures
    always @(negedge clk) begin
        if (dut0.chk0.fail_cnt != 0) begin
            abort_run("an assertion in fetch_chk failed");
        end
    end

    // ########################################
    // run control
    // ########################################

    initial begin
        wait_cycles = 0;
        while (reset !== 1'b0) begin
            @(negedge clk);
            wait_cycles++;
            if (wait_cycles > 10) begin
                abort_run("reset was never released");
            end
        end

        wait_cycles = 0;
        idle_cycles = 0;
        last_accept = 0;
        while (n_accept < 3000) begin
            @(negedge clk);
            wait_cycles++;
            if (n_accept != last_accept) begin
                idle_cycles = 0;
                last_accept = n_accept;
            end else begin
                idle_cycles++;
            end
            if (idle_cycles > 200) begin
                abort_run("fetch delivered no instruction for 200 cycles");
            end
            if (wait_cycles > 50000) begin
                abort_run("fetch did not deliver 3000 instructions in time");
            end
        end

        if (n_mispred > 0 && n_nuke > 0 && n_both > 0 && n_miss_redir > 0) begin
            $display("Test OK");
            $finish;
        end else begin
            abort_run("the random redirects missed one of the redirect cases");
        end
    end

endmodule

`default_nettype wire

// ==== tb_clkgen.sv ====
`default_nettype none

module tb_clkgen (
    output logic clk,
    output logic reset
);

    // 100 time unit period
    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    // reset seen by the dut on the first three rising edges
    initial begin
        reset = 1'b1;
        repeat (3) @(posedge clk);
        reset <= 1'b0;                   // released right after edge 3
    end

endmodule

`default_nettype wire
